// File: hdl/lsu_issue.sv
//////////////////////////////
// inst must stay stable while valid waits for ready
// Misaligned accesses still go out on the bus
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_issue import lsu_pkg::*; (
    input  wire             aclk,
    input  wire             aresetn,
    input  wire             inst_valid,
    output logic            inst_ready,
    input  wire lsu_inst_t  inst,
    input  wire data_t      rs1_val,
    input  wire data_t      rs2_val,
    output reg_idx_t        rs1_addr,
    output reg_idx_t        rs2_addr,
    // From the ordering counters
    input  wire             wr_block,
    input  wire             rd_block,
    input  wire             wr_at_max,
    input  wire             rd_at_max,
    // Accepted instruction marks
    output logic            load_issue,
    output logic            store_issue,
    output ld_ctx_t         ld_ctx,
    output lsu_exc_t        exceptions,
    // AXI4-lite request channels
    output logic            awvalid,
    input  wire             awready,
    output addr_t           aw_addr,
    output logic            wvalid,
    input  wire             wready,
    output w_payload_t      w_data,
    output logic            arvalid,
    input  wire             arready,
    output addr_t           ar_addr
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        SERVE
    } state_e;

    state_e state;
    logic   ready_fsm;
    logic   pend_store;
    logic   is_store;
    logic   accept;
    logic   is_half;
    logic   misaligned;
    addr_t  addr;
    addr_t  addr_q;

    ////////////////////////////// Decode

    assign rs1_addr = inst.rs1;
    assign rs2_addr = inst.rs2;

    // Unknown opcodes fall on the load path
    assign is_store = (inst.opcode == op_store);

    // rs1 plus sign-extended imm12
    assign addr = rs1_val + {{(XLEN-12){inst.imm12[11]}}, inst.imm12};

    assign accept      = inst_valid & inst_ready;
    assign load_issue  = accept & ~is_store;
    assign store_issue = accept & is_store;

    assign ld_ctx = '{rd: inst.rd, funct3: inst.funct3, offset: addr[1:0]};

    // Halfword on odd byte, or word off a word boundary
    assign is_half    = (inst.funct3 == f_h) || (inst.funct3 == f_hu);
    assign misaligned = (is_half && addr[0]) ||
                        (inst.funct3 == f_w && addr[1:0] != 2'b00);

    // No new instruction at either outstanding limit
    assign inst_ready = ready_fsm & ~rd_at_max & ~wr_at_max;

    ////////////////////////////// Request FSM

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state      <= IDLE;
            ready_fsm  <= 1'b0;
            pend_store <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            arvalid    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        ready_fsm  <= 1'b0;
                        pend_store <= is_store;
                        // Opposite direction still busy, park in WAIT
                        if (is_store && !rd_block) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= SERVE;
                        end else if (!is_store && !wr_block) begin
                            arvalid <= 1'b1;
                            state   <= SERVE;
                        end else begin
                            state <= WAIT;
                        end
                    end else begin
                        ready_fsm <= 1'b1;
                    end
                end

                // Wait for the last completion of the other direction
                WAIT: begin
                    if (pend_store && !rd_block) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= SERVE;
                    end else if (!pend_store && !wr_block) begin
                        arvalid <= 1'b1;
                        state   <= SERVE;
                    end
                end

                // Each channel drops on its own handshake
                SERVE: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    // Back to IDLE once nothing is left unacknowledged
                    if ((!awvalid || awready) && (!wvalid || wready) &&
                        (!arvalid || arready)) begin
                        ready_fsm <= 1'b1;
                        state     <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////// Payload

    // Captured on accept, held until the handshakes
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q      <= addr;
            w_data.data <= store_data(rs2_val, addr[1:0]);
            w_data.strb <= store_strb(inst.funct3, addr[1:0]);
        end
    end

    // Same address serves both directions
    assign aw_addr = addr_q;
    assign ar_addr = addr_q;

    ////////////////////////////// Exceptions

    // One-cycle pulse after the accepting edge
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            exceptions <= '0;
        end else begin
            exceptions.load_misaligned  <= load_issue & misaligned;
            exceptions.store_misaligned <= store_issue & misaligned;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_load_track.sv
//////////////////////////////
// Read data returns in issue order
// FIFO overflow is prevented upstream by the read limit
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_load_track import lsu_pkg::*; #(
    parameter int MAX_OR     = 8,
    parameter int NB_INT_REG = 32
) (
    input  wire                    aclk,
    input  wire                    aresetn,
    input  wire                    load_issue,
    input  wire ld_ctx_t           ld_ctx,
    input  wire                    rvalid,
    input  wire r_payload_t        r_data,
    output rd_write_t              rd_write,
    output logic [NB_INT_REG-1:0]  regs_free
);

    localparam int PTR_W = $clog2(MAX_OR);
    localparam int CNT_W = $clog2(MAX_OR) + 1;

    ld_ctx_t          fifo_mem [MAX_OR];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    ld_ctx_t          head;

    // In-flight loads per register, x0 excluded
    logic [CNT_W-1:0] busy_cnt [1:NB_INT_REG-1];

    ////////////////////////////// Context FIFO

    always_ff @(posedge aclk) begin
        if (load_issue) begin
            fifo_mem[wr_ptr] <= ld_ctx;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (load_issue) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rvalid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Oldest load matches the current completion
    assign head = fifo_mem[rd_ptr];

    ////////////////////////////// Write-back

    // Same cycle as the R handshake
    assign rd_write.wr   = rvalid;
    assign rd_write.addr = head.rd;
    assign rd_write.val  = load_value(head.funct3, r_data.data, head.offset);

    ////////////////////////////// Register busy

    assign regs_free[0] = 1'b1;

    for (genvar i = 1; i < NB_INT_REG; i++) begin : g_reg
        logic inc;
        logic dec;

        assign inc = load_issue && (ld_ctx.rd == reg_idx_t'(i));
        assign dec = rvalid && (head.rd == reg_idx_t'(i));

        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                busy_cnt[i] <= '0;
            end else if (inc && !dec) begin
                busy_cnt[i] <= busy_cnt[i] + 1'b1;
            end else if (!inc && dec) begin
                busy_cnt[i] <= busy_cnt[i] - 1'b1;
            end
        end

        // Free once every load to it has written back
        assign regs_free[i] = (busy_cnt[i] == '0);
    end

endmodule

`default_nettype wire

// File: hdl/lsu_ordering.sv
//////////////////////////////
// bready and rready assumed always high
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_ordering #(
    parameter int MAX_OR = 8
) (
    input  wire  aclk,
    input  wire  aresetn,
    input  wire  load_issue,
    input  wire  store_issue,
    input  wire  bvalid,
    input  wire  rvalid,
    output logic wr_block,
    output logic rd_block,
    output logic wr_at_max,
    output logic rd_at_max,
    output logic pending_read,
    output logic pending_write
);

    localparam int CNT_W = $clog2(MAX_OR) + 1;

    // Index 0 is the read direction, index 1 the write direction
    logic [1:0]       issue;
    logic [1:0]       done;
    logic [CNT_W-1:0] cnt [2];

    assign issue = {store_issue, load_issue};
    assign done  = {bvalid, rvalid};

    ////////////////////////////// Outstanding counters

    for (genvar d = 0; d < 2; d++) begin : g_dir
        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                cnt[d] <= '0;
            end else if (issue[d] && !done[d]) begin
                cnt[d] <= cnt[d] + 1'b1;
            end else if (!issue[d] && done[d]) begin
                cnt[d] <= cnt[d] - 1'b1;
            end
            // Issue and completion together leave the count as is
        end
    end

    ////////////////////////////// Flags

    // Outstanding writes hold back reads
    assign wr_block = (cnt[1] != '0);
    // Outstanding reads hold back writes
    assign rd_block = (cnt[0] != '0);

    assign wr_at_max = (cnt[1] == CNT_W'(MAX_OR));
    assign rd_at_max = (cnt[0] == CNT_W'(MAX_OR));

    assign pending_write = wr_block;
    assign pending_read  = rd_block;

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
//////////////////////////////
// RV32 only; alignment helpers assume 4-byte words
//////////////////////////////

`default_nettype none

package lsu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN/8-1:0] strb_t;
    typedef logic [4:0]        reg_idx_t;

    // Major opcodes, anything else is handled as a load
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    // Access width and sign
    typedef enum logic [2:0] {
        f_b  = 3'b000,
        f_h  = 3'b001,
        f_w  = 3'b010,
        f_bu = 3'b100,
        f_hu = 3'b101
    } funct3_e;

    typedef struct packed {
        opcode_e    opcode;
        funct3_e    funct3;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic [11:0] imm12;
    } lsu_inst_t;

    // Context kept for each load in flight
    typedef struct packed {
        reg_idx_t   rd;
        funct3_e    funct3;
        logic [1:0] offset;
    } ld_ctx_t;

    typedef struct packed {
        logic     wr;
        reg_idx_t addr;
        data_t    val;
    } rd_write_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_payload_t;

    typedef struct packed {
        data_t      data;
        logic [1:0] resp;
    } r_payload_t;

    typedef struct packed {
        logic load_misaligned;
        logic store_misaligned;
    } lsu_exc_t;

    ////////////////////////////// Alignment

    // Move rs2 to the byte lane of the address
    function automatic data_t store_data(data_t rs2, logic [1:0] offset);
        return rs2 << {offset, 3'b000};
    endfunction

    // Strobe follows the width, shifted to the lane
    function automatic strb_t store_strb(funct3_e funct3, logic [1:0] offset);
        strb_t base;
        case (funct3[1:0])
            2'b00:   base = strb_t'(4'b0001);
            2'b01:   base = strb_t'(4'b0011);
            default: base = strb_t'(4'b1111);
        endcase
        return base << offset;
    endfunction

    // Bring the addressed bytes to bit 0, then extend
    function automatic data_t load_value(funct3_e funct3, data_t rdata, logic [1:0] offset);
        data_t sh;
        sh = rdata >> {offset, 3'b000};
        case (funct3)
            f_b:     return {{(XLEN-8){sh[7]}}, sh[7:0]};
            f_bu:    return {{(XLEN-8){1'b0}}, sh[7:0]};
            f_h:     return {{(XLEN-16){sh[15]}}, sh[15:0]};
            f_hu:    return {{(XLEN-16){1'b0}}, sh[15:0]};
            default: return sh;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/lsu_top.sv
//////////////////////////////
// MAX_OR must be a power of two and at least 2
// Error responses on B and R are not reported
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int MAX_OR     = 8,
    parameter int NB_INT_REG = 32
) (
    input  wire                    aclk,
    input  wire                    aresetn,
    // Instruction port
    input  wire                    inst_valid,
    output logic                   inst_ready,
    input  wire lsu_inst_t         inst,
    // Register file
    output reg_idx_t               rs1_addr,
    output reg_idx_t               rs2_addr,
    input  wire data_t             rs1_val,
    input  wire data_t             rs2_val,
    output rd_write_t              rd_write,
    output logic [NB_INT_REG-1:0]  regs_free,
    // Status to the core
    output logic                   pending_read,
    output logic                   pending_write,
    output lsu_exc_t               exceptions,
    // AXI4-lite
    output logic                   awvalid,
    input  wire                    awready,
    output addr_t                  aw_addr,
    output logic                   wvalid,
    input  wire                    wready,
    output w_payload_t             w_data,
    input  wire                    bvalid,
    output logic                   bready,
    input  wire [1:0]              bresp,
    output logic                   arvalid,
    input  wire                    arready,
    output addr_t                  ar_addr,
    input  wire                    rvalid,
    output logic                   rready,
    input  wire r_payload_t        r_data
);

    logic    wr_block;
    logic    rd_block;
    logic    wr_at_max;
    logic    rd_at_max;
    logic    load_issue;
    logic    store_issue;
    ld_ctx_t ld_ctx;

    // Completions always accepted
    assign bready = 1'b1;
    assign rready = 1'b1;

    lsu_issue i_issue (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .wr_block    (wr_block),
        .rd_block    (rd_block),
        .wr_at_max   (wr_at_max),
        .rd_at_max   (rd_at_max),
        .load_issue  (load_issue),
        .store_issue (store_issue),
        .ld_ctx      (ld_ctx),
        .exceptions  (exceptions),
        .awvalid     (awvalid),
        .awready     (awready),
        .aw_addr     (aw_addr),
        .wvalid      (wvalid),
        .wready      (wready),
        .w_data      (w_data),
        .arvalid     (arvalid),
        .arready     (arready),
        .ar_addr     (ar_addr)
    );

    lsu_ordering #(.MAX_OR(MAX_OR)) i_ordering (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .load_issue    (load_issue),
        .store_issue   (store_issue),
        .bvalid        (bvalid),
        .rvalid        (rvalid),
        .wr_block      (wr_block),
        .rd_block      (rd_block),
        .wr_at_max     (wr_at_max),
        .rd_at_max     (rd_at_max),
        .pending_read  (pending_read),
        .pending_write (pending_write)
    );

    lsu_load_track #(.MAX_OR(MAX_OR), .NB_INT_REG(NB_INT_REG)) i_load_track (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .load_issue (load_issue),
        .ld_ctx     (ld_ctx),
        .rvalid     (rvalid),
        .r_data     (r_data),
        .rd_write   (rd_write),
        .regs_free  (regs_free)
    );

endmodule

`default_nettype wire

// File: lsu.f
hdl/lsu_pkg.sv
hdl/lsu_issue.sv
hdl/lsu_ordering.sv
hdl/lsu_load_track.sv
hdl/lsu_top.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module lsu_tb \
    -f lsu.f -o lsu_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/lsu_sim > sim.log 2>&1

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

// File: tb/lsu_properties.sv
//////////////////////////////
// Bound into lsu_top, checks hold only out of reset
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_properties import lsu_pkg::*; (
    input wire             aclk,
    input wire             aresetn,
    input wire             awvalid,
    input wire             awready,
    input wire addr_t      aw_addr,
    input wire             wvalid,
    input wire             wready,
    input wire w_payload_t w_data,
    input wire             arvalid,
    input wire             arready,
    input wire addr_t      ar_addr,
    input wire             rvalid,
    input wire             pending_read,
    input wire             pending_write
);

    ////////////////////////////// Request hold

    // Valid and payload stay put until the handshake
    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(aw_addr))
        else $error("AW request dropped or changed before awready");

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(w_data))
        else $error("W request dropped or changed before wready");

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar_addr))
        else $error("AR request dropped or changed before arready");

    ////////////////////////////// Ordering

    // A read never starts over outstanding writes
    ar_after_writes: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(arvalid) |-> !pending_write)
        else $error("Read request raised while writes were outstanding");

    r_only_pending: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid |-> pending_read)
        else $error("Read data returned with no read outstanding");

endmodule

bind lsu_top lsu_properties i_props (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .awvalid       (awvalid),
    .awready       (awready),
    .aw_addr       (aw_addr),
    .wvalid        (wvalid),
    .wready        (wready),
    .w_data        (w_data),
    .arvalid       (arvalid),
    .arready       (arready),
    .ar_addr       (ar_addr),
    .rvalid        (rvalid),
    .pending_read  (pending_read),
    .pending_write (pending_write)
);

`default_nettype wire

// File: tb/lsu_tb.sv
//////////////////////////////
// Memory model covers 256 words, address bits 9:2
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_tb import lsu_pkg::*;;

    localparam int MAX_OR    = 8;
    localparam int NB_REG    = 32;
    localparam int MAX_CYCLE = 20000;

    logic aclk = 1'b0;
    logic aresetn = 1'b0;
    logic inst_valid = 1'b0;
    lsu_inst_t inst = '0;
    data_t rs1_val = '0;
    data_t rs2_val = '0;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic arready = 1'b0;
    logic bvalid = 1'b0;
    logic [1:0] bresp = 2'b00;
    logic rvalid = 1'b0;
    r_payload_t r_data = '0;
    logic inst_ready, pending_read, pending_write;
    logic awvalid, wvalid, arvalid, bready, rready;
    reg_idx_t rs1_addr, rs2_addr;
    rd_write_t rd_write;
    logic [NB_REG-1:0] regs_free;
    lsu_exc_t exceptions;
    addr_t aw_addr, ar_addr;
    w_payload_t w_data;

    // Memory model state
    data_t mem [256];
    data_t exp_mem [256];
    addr_t rd_addr_q [$];
    rd_write_t exp_q [$];
    addr_t aw_q;
    w_payload_t w_q;
    logic aw_got, w_got, hold_r;
    strb_t last_strb;
    int b_pending, b_wait, r_wait, aw_count, ar_count, cycles;
    // Accepted requests still waiting for their completion
    int wr_open;
    int rd_open;
    integer seed = 32'h73121147;

    lsu_top #(.MAX_OR(MAX_OR), .NB_INT_REG(NB_REG)) i_dut (.*);

    initial begin
        forever #10 aclk = ~aclk;
    end

    function automatic data_t fill_word(int i);
        return {8'(i), 8'(i) ^ 8'hA5, ~8'(i), 8'h3C};
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    ////////////////////////////// AXI4-lite memory

    always @(posedge aclk) begin
        if (!aresetn) begin
            {awready, wready, arready, bvalid, rvalid} <= '0;
            r_data <= '0;
            aw_got = 1'b0;
            w_got = 1'b0;
            {b_pending, b_wait, r_wait, aw_count, ar_count} = '0;
            wr_open = 0;
            rd_open = 0;
            rd_addr_q.delete();
            for (int i = 0; i < 256; i++)
                mem[i] = fill_word(i);
        end else begin
            // Accepted instructions open a request in their direction
            if (inst_valid && inst_ready) begin
                if (inst.opcode == op_store)
                    wr_open++;
                else
                    rd_open++;
            end
            // Ready high about three cycles in four
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 3) != 0;
            arready <= ($random(seed) & 3) != 0;
            if (awvalid && awready) begin
                aw_q = aw_addr;
                aw_got = 1'b1;
                aw_count++;
            end
            if (wvalid && wready) begin
                w_q = w_data;
                w_got = 1'b1;
            end
            if (aw_got && w_got) begin
                for (int k = 0; k < 4; k++)
                    if (w_q.strb[k]) mem[aw_q[9:2]][8*k +: 8] = w_q.data[8*k +: 8];
                last_strb = w_q.strb;
                aw_got = 1'b0;
                w_got = 1'b0;
                b_pending++;
            end
            if (bvalid) begin
                bvalid <= 1'b0;
                wr_open--;
            end else if (b_pending > 0) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                    b_pending--;
                    b_wait = $random(seed) & 3;
                end else begin
                    b_wait--;
                end
            end
            if (arvalid && arready) begin
                rd_addr_q.push_back(ar_addr);
                ar_count++;
            end
            // Reads answer in order, hold_r withholds them
            if (rvalid) begin
                rvalid <= 1'b0;
                rd_open--;
            end else if (rd_addr_q.size() > 0 && !hold_r) begin
                if (r_wait == 0) begin
                    r_data <= '{data: mem[rd_addr_q[0][9:2]], resp: 2'b00};
                    rvalid <= 1'b1;
                    void'(rd_addr_q.pop_front());
                    r_wait = $random(seed) & 3;
                end else begin
                    r_wait--;
                end
            end
        end
    end

    ////////////////////////////// Write-back monitor and timeout

    always @(negedge aclk) begin
        rd_write_t e;
        if (aresetn) begin
            // Pending flags follow the open requests in each direction
            assert (pending_write == (wr_open != 0) && pending_read == (rd_open != 0))
                else report_fail($sformatf("pending r=%b w=%b with %0d reads, %0d writes open",
                    pending_read, pending_write, rd_open, wr_open));
            if (rd_write.wr) begin
                assert (exp_q.size() > 0) else report_fail("write-back with no load expected");
                e = exp_q.pop_front();
                assert (rd_write.addr == e.addr && rd_write.val == e.val)
                    else report_fail($sformatf("rd x%0d = %h, expected x%0d = %h",
                        rd_write.addr, rd_write.val, e.addr, e.val));
                assert (!regs_free[e.addr])
                    else report_fail("target register free before write-back");
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLE);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    ////////////////////////////// Driver tasks

    function automatic addr_t eff_addr(data_t base, logic [11:0] imm);
        return base + {{20{imm[11]}}, imm};
    endfunction

    // Expected load result from the reference memory
    function automatic data_t load_expect(funct3_e f, addr_t a);
        data_t sh;
        sh = exp_mem[a[9:2]] >> {a[1:0], 3'b000};
        case (f)
            f_b:     return {{24{sh[7]}}, sh[7:0]};
            f_bu:    return {24'h0, sh[7:0]};
            f_h:     return {{16{sh[15]}}, sh[15:0]};
            f_hu:    return {16'h0, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    // Hold the instruction until accepted, return the exception flags
    task automatic send(input lsu_inst_t ins, input data_t v1, input data_t v2,
                        output lsu_exc_t exc);
        addr_t a;
        logic mis;
        a = eff_addr(v1, ins.imm12);
        // Halfword on an odd byte or word off its boundary
        case (ins.funct3)
            f_h, f_hu: mis = a[0];
            f_w:       mis = (a[1:0] != 2'b00);
            default:   mis = 1'b0;
        endcase
        @(posedge aclk);
        inst <= ins;
        rs1_val <= v1;
        rs2_val <= v2;
        inst_valid <= 1'b1;
        do @(negedge aclk); while (!inst_ready);
        assert (rs1_addr == ins.rs1 && rs2_addr == ins.rs2)
            else report_fail($sformatf("register reads x%0d x%0d, expected x%0d x%0d",
                rs1_addr, rs2_addr, ins.rs1, ins.rs2));
        @(posedge aclk);
        inst_valid <= 1'b0;
        @(negedge aclk);
        exc = exceptions;
        assert (exc.load_misaligned == (mis && ins.opcode != op_store) &&
                exc.store_misaligned == (mis && ins.opcode == op_store))
            else report_fail($sformatf("exception flags %b at address %h", exc, a));
    endtask

    task automatic store(input funct3_e f, input data_t v1, input logic [11:0] imm,
                         input data_t v2, output lsu_exc_t exc, output strb_t strb);
        addr_t a;
        strb_t mask;
        data_t d;
        a = eff_addr(v1, imm);
        mask = (f == f_b) ? 4'b0001 : (f == f_h) ? 4'b0011 : 4'b1111;
        strb = 4'(mask << a[1:0]);
        d = v2 << (8 * a[1:0]);
        for (int k = 0; k < 4; k++)
            if (strb[k]) exp_mem[a[9:2]][8*k +: 8] = d[8*k +: 8];
        send('{opcode: op_store, funct3: f, rs1: 5'd1, rs2: 5'd2, rd: 5'd0, imm12: imm},
             v1, v2, exc);
        assert (pending_write) else report_fail("pending_write low after store accept");
    endtask

    task automatic load(input funct3_e f, input reg_idx_t rd, input data_t v1,
                        input logic [11:0] imm, output lsu_exc_t exc);
        exp_q.push_back('{wr: 1'b1, addr: rd, val: load_expect(f, eff_addr(v1, imm))});
        send('{opcode: op_load, funct3: f, rs1: 5'd1, rs2: 5'd0, rd: rd, imm12: imm},
             v1, '0, exc);
    endtask

    // Wait for all traffic to finish, then compare state
    task automatic drain();
        do @(negedge aclk); while (exp_q.size() != 0 || pending_read || pending_write);
        assert (regs_free == '1) else report_fail("registers still busy after drain");
        for (int i = 0; i < 256; i++)
            assert (mem[i] == exp_mem[i])
                else report_fail($sformatf("memory word %0d = %h, expected %h",
                    i, mem[i], exp_mem[i]));
    endtask

    ////////////////////////////// Tests

    task automatic word_round_trip();
        lsu_exc_t e;
        strb_t s;
        store(f_w, 32'h140, 12'hFF0, 32'hDEADBEEF, e, s);
        store(f_w, 32'h100, 12'h024, 32'h12345678, e, s);
        load(f_w, 5'd5, 32'h140, 12'hFF0, e);
        load(f_w, 5'd6, 32'h100, 12'h024, e);
        drain();
    endtask

    task automatic subword_access();
        lsu_exc_t e;
        strb_t s;
        store(f_b, 32'h200, 12'h001, 32'h0000009C, e, s);
        drain();
        assert (last_strb == s) else report_fail($sformatf("SB strobe %b", last_strb));
        store(f_h, 32'h200, 12'h006, 32'h00008123, e, s);
        drain();
        assert (last_strb == s) else report_fail($sformatf("SH strobe %b", last_strb));
        load(f_b, 5'd7, 32'h200, 12'h001, e);
        load(f_bu, 5'd8, 32'h200, 12'h001, e);
        load(f_h, 5'd9, 32'h200, 12'h006, e);
        load(f_hu, 5'd10, 32'h200, 12'h006, e);
        load(f_w, 5'd11, 32'h200, 12'h004, e);
        drain();
    endtask

    task automatic misaligned_access();
        lsu_exc_t e;
        strb_t s;
        int n;
        n = ar_count;
        load(f_w, 5'd12, 32'h300, 12'h002, e);
        assert (e.load_misaligned && !e.store_misaligned) else report_fail("LW flag missing");
        @(negedge aclk);
        assert (exceptions == '0) else report_fail("load exception longer than one cycle");
        drain();
        assert (ar_count == n + 1) else report_fail("misaligned load never reached the bus");
        n = aw_count;
        store(f_h, 32'h310, 12'h003, 32'h0000BEAD, e, s);
        assert (e.store_misaligned && !e.load_misaligned) else report_fail("SH flag missing");
        @(negedge aclk);
        assert (exceptions == '0) else report_fail("store exception longer than one cycle");
        drain();
        assert (aw_count == n + 1) else report_fail("misaligned store never reached the bus");
    endtask

    task automatic store_then_load();
        lsu_exc_t e;
        strb_t s;
        store(f_w, 32'h400, 12'h000, 32'hA1A1A1A1, e, s);
        store(f_w, 32'h400, 12'h004, 32'hB2B2B2B2, e, s);
        store(f_w, 32'h400, 12'h004, 32'hC3C3C3C3, e, s);
        load(f_w, 5'd13, 32'h400, 12'h004, e);
        drain();
    endtask

    task automatic outstanding_limit();
        lsu_exc_t e;
        hold_r = 1'b1;
        for (int k = 1; k <= MAX_OR; k++)
            load(f_w, reg_idx_t'(k), 32'h500, 12'(4 * k), e);
        exp_q.push_back('{wr: 1'b1, addr: 5'd9, val: load_expect(f_w, 32'h540)});
        @(posedge aclk);
        inst <= '{opcode: op_load, funct3: f_w, rs1: 5'd1, rs2: 5'd0, rd: 5'd9, imm12: 12'h040};
        rs1_val <= 32'h500;
        inst_valid <= 1'b1;
        repeat (10) begin
            @(negedge aclk);
            assert (!inst_ready) else report_fail("load accepted past the outstanding limit");
        end
        assert (regs_free[8:1] == '0) else report_fail("busy register reported free");
        hold_r = 1'b0;
        do @(negedge aclk); while (!inst_ready);
        @(posedge aclk);
        inst_valid <= 1'b0;
        drain();
    endtask

    initial begin
        hold_r = 1'b0;
        cycles = 0;
        for (int i = 0; i < 256; i++)
            exp_mem[i] = fill_word(i);
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        assert (regs_free == '1 && !pending_read && !pending_write && !inst_ready &&
                !awvalid && !wvalid && !arvalid && !rd_write.wr && exceptions == '0)
            else report_fail("unexpected state after reset");
        assert (bready && rready) else report_fail("bready or rready not held high");
        word_round_trip();
        subword_access();
        misaligned_access();
        store_then_load();
        outstanding_limit();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
